/* cpuDatapath.f */
common/datapathPkg.sv
common/dpCtrlIf.sv
regfile/selectEncode.sv
regfile/registerFile.sv
alu/alu.sv
rtl/specialRegs.sv
rtl/memoryUnit.sv
rtl/busMux.sv
rtl/conFf.sv
rtl/cpuDatapath.sv
verif/tbClock.sv
verif/tbCpuDatapath.sv

/* Bender.yml */
package:
  name: cpuDatapath

sources:
  - common/datapathPkg.sv
  - common/dpCtrlIf.sv
  - regfile/selectEncode.sv
  - regfile/registerFile.sv
  - alu/alu.sv
  - rtl/specialRegs.sv
  - rtl/memoryUnit.sv
  - rtl/busMux.sv
  - rtl/conFf.sv
  - rtl/cpuDatapath.sv
  - target: test
    files:
      - verif/tbClock.sv
      - verif/tbCpuDatapath.sv

/* verif/tbCpuDatapath.sv */
`timescale 1ns/10ps
module tbCpuDatapath;
    import datapathPkg::*;

    localparam int MAX_STEPS = 128;
    localparam int RESET_CYCLES = 16;
    localparam int CHK_NONE = 0;
    localparam int CHK_BUS  = 1;
    localparam int CHK_OUT  = 2;
    localparam int CHK_CON  = 3;
    localparam word_t ORI_INSTR = 32'h7118_0025;   // ori R2, R3, 0x25
    localparam word_t IR_RA3 = 32'h0180_0000;
    // One bit per strobe, in the order of the DUT hookup
    localparam logic [26:0] PC_IN   = 27'd1;
    localparam logic [26:0] IR_IN   = 27'd1 << 1;
    localparam logic [26:0] Y_IN    = 27'd1 << 2;
    localparam logic [26:0] Z_IN    = 27'd1 << 3;
    localparam logic [26:0] HI_IN   = 27'd1 << 4;
    localparam logic [26:0] LO_IN   = 27'd1 << 5;
    localparam logic [26:0] MAR_IN  = 27'd1 << 6;
    localparam logic [26:0] MDR_IN  = 27'd1 << 7;
    localparam logic [26:0] OUT_IN  = 27'd1 << 8;
    localparam logic [26:0] CON_IN  = 27'd1 << 9;
    localparam logic [26:0] R_IN    = 27'd1 << 10;
    localparam logic [26:0] PC_OUT  = 27'd1 << 11;
    localparam logic [26:0] ZH_OUT  = 27'd1 << 12;
    localparam logic [26:0] ZL_OUT  = 27'd1 << 13;
    localparam logic [26:0] HI_OUT  = 27'd1 << 14;
    localparam logic [26:0] LO_OUT  = 27'd1 << 15;
    localparam logic [26:0] MDR_OUT = 27'd1 << 16;
    localparam logic [26:0] INP_OUT = 27'd1 << 17;
    localparam logic [26:0] C_OUT   = 27'd1 << 18;
    localparam logic [26:0] R_OUT   = 27'd1 << 19;
    localparam logic [26:0] BA_OUT  = 27'd1 << 20;
    localparam logic [26:0] READ    = 27'd1 << 21;
    localparam logic [26:0] WRITE   = 27'd1 << 22;
    localparam logic [26:0] GRA     = 27'd1 << 23;
    localparam logic [26:0] GRB     = 27'd1 << 24;
    localparam logic [26:0] INC_PC  = 27'd1 << 26;

    logic        clk, rstN, conOut;
    logic [26:0] strobes;
    aluOp_t      aluOp;
    word_t       inPortData, busData, outPortData;

    string       stepName [MAX_STEPS];
    logic [26:0] stepStrobes [MAX_STEPS];
    aluOp_t      stepOp [MAX_STEPS];
    word_t       stepIn [MAX_STEPS];
    int          stepKind [MAX_STEPS];
    word_t       stepExp [MAX_STEPS];
    int          numSteps = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 2 * (MAX_STEPS + RESET_CYCLES);
    logic [15:0] lfsr = 16'd57;

    tbClock clockGen (.clk(clk), .rstN(rstN));

    cpuDatapath DUT (.clk(clk), .rstN(rstN),
        .pcIn(strobes[0]), .irIn(strobes[1]), .yIn(strobes[2]), .zIn(strobes[3]),
        .hiIn(strobes[4]), .loIn(strobes[5]), .marIn(strobes[6]), .mdrIn(strobes[7]),
        .outPortIn(strobes[8]), .conIn(strobes[9]), .rIn(strobes[10]),
        .pcOut(strobes[11]), .zHighOut(strobes[12]), .zLowOut(strobes[13]),
        .hiOut(strobes[14]), .loOut(strobes[15]), .mdrOut(strobes[16]),
        .inPortOut(strobes[17]), .cOut(strobes[18]), .rOut(strobes[19]),
        .baOut(strobes[20]), .read(strobes[21]), .write(strobes[22]), .gra(strobes[23]),
        .grb(strobes[24]), .grc(strobes[25]), .incPc(strobes[26]), .aluOp(aluOp),
        .inPortData(inPortData), .busData(busData), .outPortData(outPortData),
        .conOut(conOut));

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int n, output word_t value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic dword_t aluModel(input aluOp_t op, input word_t a, input word_t b);
        word_t r;
        int    n;
        r = a;
        n = b[4:0];
        case (op)
            OP_ADD: return {32'b0, a + b};
            OP_SUB: return {32'b0, a - b};
            OP_AND: return {32'b0, a & b};
            OP_OR:  return {32'b0, a | b};
            OP_SHR, OP_SHRA, OP_SHL, OP_ROR, OP_ROL: begin
                repeat (n) begin   // One bit position per pass
                    case (op)
                        OP_SHR:  r = {1'b0, r[31:1]};
                        OP_SHRA: r = {r[31], r[31:1]};
                        OP_SHL:  r = {r[30:0], 1'b0};
                        OP_ROR:  r = {r[0], r[31:1]};
                        default: r = {r[30:0], r[31]};
                    endcase
                end
                return {32'b0, r};
            end
            OP_MUL: return $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            OP_NEG: return {32'b0, 32'd0 - b};
            OP_NOT: return {32'b0, ~b};
            default: return '0;
        endcase
    endfunction

    function automatic word_t conModel(input int code, input word_t v);
        case (code)
            BR_ZERO:    return word_t'(v == 0);
            BR_NONZERO: return word_t'(v != 0);
            BR_POS:     return word_t'(!v[31] && v != 0);
            default:    return word_t'(v[31]);
        endcase
    endfunction

    task automatic addStep(input string name, input logic [26:0] s, input aluOp_t op,
                           input word_t din, input int kind, input word_t exp);
        stepName[numSteps] = name;
        stepStrobes[numSteps] = s;
        stepOp[numSteps] = op;
        stepIn[numSteps] = din;   // inPort shows it on the next step
        stepKind[numSteps] = kind;
        stepExp[numSteps] = exp;
        numSteps++;
    endtask

    task automatic buildTable();
        word_t  a, b, v, oriExp;
        word_t  conVals [3];
        dword_t res;
        aluOp_t aluOps [12];
        aluOps = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SHR, OP_SHRA, OP_SHL, OP_ROR,
                   OP_ROL, OP_NEG, OP_NOT, OP_MUL};
        oriExp = 32'hF1 | 32'h25;   // R3 ored with the constant
        addStep("idleBus", '0, '0, '0, CHK_BUS, '0);
        drawBits(32, v);
        addStep("irPrep", '0, '0, IR_RA3, CHK_NONE, '0);
        addStep("irLoadRa3", INP_OUT | IR_IN, '0, v, CHK_NONE, '0);
        addStep("r3Load", INP_OUT | GRA | R_IN, '0, '0, CHK_NONE, '0);
        addStep("r3ToOutPort", GRA | R_OUT | OUT_IN, '0, '0, CHK_OUT, v);
        addStep("irLoadRa0", INP_OUT | IR_IN, '0, v, CHK_NONE, '0);
        addStep("r0Load", INP_OUT | GRA | R_IN, '0, '0, CHK_NONE, '0);
        addStep("r0Drive", GRA | R_OUT, '0, '0, CHK_BUS, v);
        addStep("r0BaseZero", GRA | BA_OUT, '0, '0, CHK_BUS, '0);
        // Program setup followed by fetch and ori
        addStep("irPrepB", '0, '0, IR_RA3, CHK_NONE, '0);
        addStep("irLoadRa3B", INP_OUT | IR_IN, '0, 32'hF1, CHK_NONE, '0);
        addStep("r3Preload", INP_OUT | GRA | R_IN, '0, '0, CHK_NONE, '0);
        addStep("pcMarClear", INP_OUT | PC_IN | MAR_IN, '0, ORI_INSTR, CHK_NONE, '0);
        addStep("mdrLoadInstr", INP_OUT | MDR_IN, '0, '0, CHK_NONE, '0);
        addStep("ramWriteInstr", WRITE, '0, '0, CHK_NONE, '0);
        addStep("fetchT0", PC_OUT | MAR_IN | INC_PC | Z_IN, '0, '0, CHK_BUS, '0);
        addStep("fetchT1", ZL_OUT | PC_IN | READ | MDR_IN, '0, '0, CHK_BUS, 32'd1);
        addStep("fetchT2", MDR_OUT | IR_IN, '0, '0, CHK_BUS, ORI_INSTR);
        addStep("oriT3", GRB | R_OUT | Y_IN, '0, '0, CHK_BUS, 32'hF1);
        addStep("oriT4", C_OUT | Z_IN, OP_OR, '0, CHK_BUS, 32'h25);
        addStep("oriT5", ZL_OUT | GRA | R_IN, '0, '0, CHK_BUS, oriExp);
        addStep("r2ToOutPort", GRA | R_OUT | OUT_IN, '0, '0, CHK_OUT, oriExp);
        foreach (aluOps[i]) begin
            drawBits(32, a);
            drawBits(32, b);
            if (aluOps[i] >= OP_SHR && aluOps[i] <= OP_ROL) begin
                b[0] = 1'b1;   // Nonzero shift amount
            end
            if (aluOps[i] == OP_SHRA) begin
                a[31] = 1'b1;  // Sign bit must be copied in
            end
            res = aluModel(aluOps[i], a, b);
            addStep("aluPrepA", '0, '0, a, CHK_NONE, '0);
            addStep("aluLoadY", INP_OUT | Y_IN, '0, b, CHK_NONE, '0);
            addStep($sformatf("aluOp%0d", aluOps[i]), INP_OUT | Z_IN, aluOps[i], '0,
                    CHK_NONE, '0);
            if (aluOps[i] == OP_MUL) begin
                addStep("mulHiLoad", ZH_OUT | HI_IN, '0, '0, CHK_NONE, '0);
                addStep("mulLoLoad", ZL_OUT | LO_IN, '0, '0, CHK_NONE, '0);
                addStep("mulHiOut", HI_OUT | OUT_IN, '0, '0, CHK_OUT, res[63:32]);
                addStep("mulLoOut", LO_OUT | OUT_IN, '0, '0, CHK_OUT, res[31:0]);
            end else begin
                addStep($sformatf("aluOp%0dOut", aluOps[i]), ZL_OUT | OUT_IN, '0, '0,
                        CHK_OUT, res[31:0]);
            end
        end
        // Zero, positive and negative on the bus for every C2 code
        for (int code = 0; code < 4; code++) begin
            drawBits(32, v);
            conVals = '{32'd0, {1'b0, v[30:1], 1'b1}, v | 32'h8000_0000};
            addStep("conIrPrep", '0, '0, word_t'(code) << C2_LSB, CHK_NONE, '0);
            addStep("conIrLoad", INP_OUT | IR_IN, '0, conVals[0], CHK_NONE, '0);
            for (int j = 0; j < 3; j++) begin
                addStep($sformatf("con%0dVal%0d", code, j), INP_OUT | CON_IN, '0,
                        (j < 2) ? conVals[j + 1] : '0, CHK_CON, conModel(code, conVals[j]));
            end
        end
        drawBits(9, a);
        drawBits(32, v);
        addStep("memAddrPrep", '0, '0, a, CHK_NONE, '0);
        addStep("memMarLoad", INP_OUT | MAR_IN, '0, v, CHK_NONE, '0);
        addStep("memMdrLoad", INP_OUT | MDR_IN, '0, '0, CHK_NONE, '0);
        addStep("memWrite", WRITE, '0, '0, CHK_NONE, '0);
        addStep("memMdrClear", INP_OUT | MDR_IN, '0, '0, CHK_NONE, '0);
        addStep("memRead", READ | MDR_IN, '0, '0, CHK_NONE, '0);
        addStep("memReadBack", MDR_OUT, '0, '0, CHK_BUS, v);
    endtask

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Ports show a load step's result one cycle later
    task automatic checkPorts(input int i);
        if (stepKind[i] == CHK_OUT) begin
            checkValue(stepName[i], stepExp[i], outPortData);
        end else if (stepKind[i] == CHK_CON) begin
            checkValue(stepName[i], stepExp[i], {31'b0, conOut});
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run still going after %0d cycles", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        strobes = '0;
        aluOp = '0;
        inPortData = '0;
        buildTable();
        cycleLimit = 2 * (numSteps + RESET_CYCLES);
        wait (rstN === 1'b1);
        @(posedge clk);
        #1;
        checkValue("resetOutPort", '0, outPortData);
        checkValue("resetCon", '0, {31'b0, conOut});
        for (int i = 0; i < numSteps; i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                checkPorts(i - 1);
            end
            #1;
            strobes = stepStrobes[i];
            aluOp = stepOp[i];
            inPortData = stepIn[i];
            #16;   // Bus has settled two ns before the next edge
            if (stepKind[i] == CHK_BUS) begin
                checkValue(stepName[i], stepExp[i], busData);
            end
        end
        @(posedge clk);
        #1;
        checkPorts(numSteps - 1);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verif/tbClock.sv */
`timescale 1ns/10ps
module tbClock (
    output logic clk,
    output logic rstN
);
    localparam int HALF_PERIOD  = 10;   // 20 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release just after an edge, like the other stimulus
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rstN = 1'b1;
    end

endmodule

/* rtl/cpuDatapath.sv */
`timescale 1ns/10ps
module cpuDatapath (
    input  logic                clk,
    input  logic                rstN,
    input  logic                pcIn, irIn, yIn, zIn, hiIn, loIn,
    input  logic                marIn, mdrIn, outPortIn, conIn, rIn,
    input  logic                pcOut, zHighOut, zLowOut, hiOut, loOut,
    input  logic                mdrOut, inPortOut, cOut, rOut, baOut,
    input  logic                read, write,
    input  logic                gra, grb, grc,
    input  logic                incPc,
    input  datapathPkg::aluOp_t aluOp,
    input  datapathPkg::word_t  inPortData,
    output datapathPkg::word_t  busData,
    output datapathPkg::word_t  outPortData,
    output logic                conOut
);
    import datapathPkg::*;

    dpCtrlIf ctrl ();

    regMask_t regLoad;
    regMask_t regDrive;
    word_t    regData;
    word_t    cSignExt;
    word_t    pc;
    word_t    ir;
    word_t    y;
    word_t    zHigh;
    word_t    zLow;
    word_t    hi;
    word_t    lo;
    word_t    inPort;
    word_t    mdr;
    dword_t   aluResult;

    // Strobes come straight from the top-level pins
    assign ctrl.pcIn      = pcIn;
    assign ctrl.irIn      = irIn;
    assign ctrl.yIn       = yIn;
    assign ctrl.zIn       = zIn;
    assign ctrl.hiIn      = hiIn;
    assign ctrl.loIn      = loIn;
    assign ctrl.marIn     = marIn;
    assign ctrl.mdrIn     = mdrIn;
    assign ctrl.outPortIn = outPortIn;
    assign ctrl.conIn     = conIn;
    assign ctrl.rIn       = rIn;
    assign ctrl.pcOut     = pcOut;
    assign ctrl.zHighOut  = zHighOut;
    assign ctrl.zLowOut   = zLowOut;
    assign ctrl.hiOut     = hiOut;
    assign ctrl.loOut     = loOut;
    assign ctrl.mdrOut    = mdrOut;
    assign ctrl.inPortOut = inPortOut;
    assign ctrl.cOut      = cOut;
    assign ctrl.rOut      = rOut;
    assign ctrl.baOut     = baOut;
    assign ctrl.read      = read;
    assign ctrl.write     = write;
    assign ctrl.gra       = gra;
    assign ctrl.grb       = grb;
    assign ctrl.grc       = grc;
    assign ctrl.incPc     = incPc;
    assign ctrl.aluOp     = aluOp;

    selectEncode uSel (.ctrl(ctrl.sel), .ir(ir), .regLoad(regLoad),
                       .regDrive(regDrive), .cSignExt(cSignExt));

    registerFile uRegs (.clk(clk), .rstN(rstN), .ctrl(ctrl.regs), .busData(busData),
                        .regLoad(regLoad), .regDrive(regDrive), .regData(regData));

    specialRegs uSpecial (.clk(clk), .rstN(rstN), .ctrl(ctrl.regs), .busData(busData),
                          .aluResult(aluResult), .inPortData(inPortData), .pc(pc),
                          .ir(ir), .y(y), .zHigh(zHigh), .zLow(zLow), .hi(hi), .lo(lo),
                          .inPort(inPort), .outPortData(outPortData));

    // Y is operand A, the bus is operand B
    alu uAlu (.ctrl(ctrl.alu), .a(y), .b(busData), .result(aluResult));

    memoryUnit uMem (.clk(clk), .rstN(rstN), .ctrl(ctrl.mem), .busData(busData), .mdr(mdr));

    busMux uBus (.ctrl(ctrl.bus), .regData(regData), .pc(pc), .zHigh(zHigh), .zLow(zLow),
                 .hi(hi), .lo(lo), .mdr(mdr), .inPort(inPort), .cSignExt(cSignExt),
                 .busData(busData));

    conFf uCon (.clk(clk), .rstN(rstN), .ctrl(ctrl.con), .ir(ir), .busData(busData),
                .conOut(conOut));

endmodule

/* rtl/conFf.sv */
`timescale 1ns/10ps
module conFf (
    input  logic               clk,
    input  logic               rstN,
    dpCtrlIf.con               ctrl,
    input  datapathPkg::word_t ir,
    input  datapathPkg::word_t busData,
    output logic               conOut
);
    import datapathPkg::*;

    logic [C2_MSB-C2_LSB:0] c2;
    logic                   cond;

    assign c2 = ir[C2_MSB:C2_LSB];

    // Positive means sign clear and not zero
    always_comb begin
        case (c2)
            BR_ZERO:    cond = (busData == '0);
            BR_NONZERO: cond = (busData != '0);
            BR_POS:     cond = !busData[31] && (busData != '0);
            BR_NEG:     cond = busData[31];
            default:    cond = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            conOut <= 1'b0;
        end else if (ctrl.conIn) begin
            conOut <= cond;
        end
    end

endmodule

/* rtl/busMux.sv */
`timescale 1ns/10ps
module busMux (
    dpCtrlIf.bus               ctrl,
    input  datapathPkg::word_t regData,
    input  datapathPkg::word_t pc,
    input  datapathPkg::word_t zHigh,
    input  datapathPkg::word_t zLow,
    input  datapathPkg::word_t hi,
    input  datapathPkg::word_t lo,
    input  datapathPkg::word_t mdr,
    input  datapathPkg::word_t inPort,
    input  datapathPkg::word_t cSignExt,
    output datapathPkg::word_t busData
);

    always_comb begin
        if (ctrl.rOut || ctrl.baOut) begin
            busData = regData;   // Register file already applied the R0 rule
        end else if (ctrl.pcOut) begin
            busData = pc;
        end else if (ctrl.zHighOut) begin
            busData = zHigh;
        end else if (ctrl.zLowOut) begin
            busData = zLow;
        end else if (ctrl.hiOut) begin
            busData = hi;
        end else if (ctrl.loOut) begin
            busData = lo;
        end else if (ctrl.mdrOut) begin
            busData = mdr;
        end else if (ctrl.inPortOut) begin
            busData = inPort;
        end else if (ctrl.cOut) begin
            busData = cSignExt;
        end else begin
            busData = '0;        // Idle bus
        end
    end

endmodule

/* rtl/memoryUnit.sv */
`timescale 1ns/10ps
module memoryUnit (
    input  logic               clk,
    input  logic               rstN,
    dpCtrlIf.mem               ctrl,
    input  datapathPkg::word_t busData,
    output datapathPkg::word_t mdr
);
    import datapathPkg::*;

    word_t                 mar;
    word_t                 ram [MEM_DEPTH];
    logic [MEM_ADDR_W-1:0] addr;

    // Only the low address bits reach the RAM
    assign addr = mar[MEM_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (ctrl.marIn) begin
                mar <= busData;
            end
            if (ctrl.mdrIn) begin
                mdr <= ctrl.read ? ram[addr] : busData;  // Read is combinational
            end
        end
    end

    // RAM contents survive reset
    always_ff @(posedge clk) begin
        if (ctrl.write) begin
            ram[addr] <= mdr;
        end
    end

endmodule

/* rtl/specialRegs.sv */
`timescale 1ns/10ps
module specialRegs (
    input  logic                clk,
    input  logic                rstN,
    dpCtrlIf.regs               ctrl,
    input  datapathPkg::word_t  busData,
    input  datapathPkg::dword_t aluResult,
    input  datapathPkg::word_t  inPortData,
    output datapathPkg::word_t  pc,
    output datapathPkg::word_t  ir,
    output datapathPkg::word_t  y,
    output datapathPkg::word_t  zHigh,
    output datapathPkg::word_t  zLow,
    output datapathPkg::word_t  hi,
    output datapathPkg::word_t  lo,
    output datapathPkg::word_t  inPort,
    output datapathPkg::word_t  outPortData
);
    import datapathPkg::*;

    dword_t z;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc          <= '0;
            ir          <= '0;
            y           <= '0;
            z           <= '0;
            hi          <= '0;
            lo          <= '0;
            inPort      <= '0;
            outPortData <= '0;
        end else begin
            inPort <= inPortData;   // Sampled every cycle
            if (ctrl.pcIn) begin
                pc <= busData;
            end
            if (ctrl.irIn) begin
                ir <= busData;
            end
            if (ctrl.yIn) begin
                y <= busData;       // Operand A for the next ALU step
            end
            if (ctrl.zIn) begin
                z <= aluResult;
            end
            if (ctrl.hiIn) begin
                hi <= busData;
            end
            if (ctrl.loIn) begin
                lo <= busData;
            end
            if (ctrl.outPortIn) begin
                outPortData <= busData;
            end
        end
    end

    assign zHigh = z[63:32];
    assign zLow  = z[31:0];

endmodule

/* alu/alu.sv */
`timescale 1ns/10ps
module alu (
    dpCtrlIf.alu                ctrl,
    input  datapathPkg::word_t  a,
    input  datapathPkg::word_t  b,
    output datapathPkg::dword_t result
);
    import datapathPkg::*;

    logic [4:0] shAmt;
    dword_t     rorWide;
    dword_t     rolWide;
    dword_t     product;
    word_t      lowRes;

    assign shAmt = b[4:0];

    // Rotates come from shifting a doubled copy of a
    assign rorWide = {a, a} >> shAmt;
    assign rolWide = {a, a} << shAmt;

    // Operands sign-extend to 64 bits before the multiply
    assign product = $signed(a) * $signed(b);

    always_comb begin
        case (ctrl.aluOp)
            OP_ADD:  lowRes = a + b;
            OP_SUB:  lowRes = a - b;
            OP_AND:  lowRes = a & b;
            OP_OR:   lowRes = a | b;
            OP_SHR:  lowRes = a >> shAmt;
            OP_SHRA: lowRes = $signed(a) >>> shAmt;
            OP_SHL:  lowRes = a << shAmt;
            OP_ROR:  lowRes = rorWide[31:0];
            OP_ROL:  lowRes = rolWide[63:32];
            OP_NEG:  lowRes = -b;   // Unary ops work on the bus operand
            OP_NOT:  lowRes = ~b;
            default: lowRes = '0;
        endcase
    end

    always_comb begin
        if (ctrl.incPc) begin
            result = {32'b0, b + 32'd1};   // PC increment ignores aluOp
        end else if (ctrl.aluOp == OP_MUL) begin
            result = product;
        end else begin
            result = {32'b0, lowRes};      // High half stays zero
        end
    end

endmodule

/* regfile/registerFile.sv */
`timescale 1ns/10ps
module registerFile (
    input  logic                  clk,
    input  logic                  rstN,
    dpCtrlIf.regs                 ctrl,
    input  datapathPkg::word_t    busData,
    input  datapathPkg::regMask_t regLoad,
    input  datapathPkg::regMask_t regDrive,
    output datapathPkg::word_t    regData
);
    import datapathPkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (regLoad[i]) begin
                    regs[i] <= busData;  // Captured at the edge ending the step
                end
            end
        end
    end

    // One-hot read, R0 acts as a zero base under baOut
    always_comb begin
        regData = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (regDrive[i] && !(i == 0 && ctrl.baOut)) begin
                regData |= regs[i];
            end
        end
    end

endmodule

/* regfile/selectEncode.sv */
`timescale 1ns/10ps
module selectEncode (
    dpCtrlIf.sel                  ctrl,
    input  datapathPkg::word_t    ir,
    output datapathPkg::regMask_t regLoad,
    output datapathPkg::regMask_t regDrive,
    output datapathPkg::word_t    cSignExt
);
    import datapathPkg::*;

    regIdx_t  regSel;
    regMask_t regOneHot;

    // Only one of gra, grb, grc is raised in a step
    assign regSel = ({$bits(regIdx_t){ctrl.gra}} & ir[RA_MSB:RA_LSB])
                  | ({$bits(regIdx_t){ctrl.grb}} & ir[RB_MSB:RB_LSB])
                  | ({$bits(regIdx_t){ctrl.grc}} & ir[RC_MSB:RC_LSB]);

    assign regOneHot = regMask_t'(1) << regSel;

    assign regLoad  = ctrl.rIn ? regOneHot : '0;
    assign regDrive = (ctrl.rOut || ctrl.baOut) ? regOneHot : '0;

    // Constant C sign-extended from bit 18
    assign cSignExt = {{(31 - C_MSB){ir[C_MSB]}}, ir[C_MSB:0]};

endmodule

/* common/dpCtrlIf.sv */
`timescale 1ns/10ps
interface dpCtrlIf;
    import datapathPkg::*;

    // Load strobes
    logic pcIn, irIn, yIn, zIn, hiIn, loIn;
    logic marIn, mdrIn, outPortIn, conIn, rIn;
    // Drive strobes, at most one high per step
    logic pcOut, zHighOut, zLowOut, hiOut, loOut;
    logic mdrOut, inPortOut, cOut, rOut, baOut;
    logic read, write;
    logic gra, grb, grc;  // Register field selects
    logic incPc;
    aluOp_t aluOp;

    modport regs (input pcIn, irIn, yIn, zIn, hiIn, loIn, outPortIn, baOut);
    modport sel  (input gra, grb, grc, rIn, rOut, baOut);
    modport alu  (input incPc, aluOp);
    modport mem  (input marIn, mdrIn, read, write);
    modport bus  (input pcOut, zHighOut, zLowOut, hiOut, loOut,
                  mdrOut, inPortOut, cOut, rOut, baOut);
    modport con  (input conIn);

endinterface

/* common/datapathPkg.sv */
package datapathPkg;

    typedef logic [31:0] word_t;     // Bus, register and port word
    typedef logic [63:0] dword_t;    // Full ALU result held in Z
    typedef logic [3:0]  regIdx_t;   // Register number from an IR field
    typedef logic [15:0] regMask_t;  // One-hot general register select
    typedef logic [4:0]  aluOp_t;

    localparam int NUM_REGS = $bits(regMask_t);

    // ALU operation codes, anything else yields zero
    localparam aluOp_t OP_ADD  = 5'd3;
    localparam aluOp_t OP_SUB  = 5'd4;
    localparam aluOp_t OP_AND  = 5'd5;
    localparam aluOp_t OP_OR   = 5'd6;
    localparam aluOp_t OP_SHR  = 5'd7;   // Logical
    localparam aluOp_t OP_SHRA = 5'd8;   // Arithmetic
    localparam aluOp_t OP_SHL  = 5'd9;
    localparam aluOp_t OP_ROR  = 5'd10;
    localparam aluOp_t OP_ROL  = 5'd11;
    localparam aluOp_t OP_MUL  = 5'd15;  // Signed, full 64-bit product
    localparam aluOp_t OP_NEG  = 5'd17;
    localparam aluOp_t OP_NOT  = 5'd18;

    // Instruction field positions
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 27;
    localparam int RA_MSB  = 26;
    localparam int RA_LSB  = 23;
    localparam int RB_MSB  = 22;
    localparam int RB_LSB  = 19;
    localparam int RC_MSB  = 18;
    localparam int RC_LSB  = 15;
    localparam int C_MSB   = 18;  // Constant C runs down to bit 0
    localparam int C2_MSB  = 20;
    localparam int C2_LSB  = 19;

    // Branch condition codes in C2
    localparam logic [1:0] BR_ZERO    = 2'd0;
    localparam logic [1:0] BR_NONZERO = 2'd1;
    localparam logic [1:0] BR_POS     = 2'd2;
    localparam logic [1:0] BR_NEG     = 2'd3;

    localparam int MEM_DEPTH  = 512;
    localparam int MEM_ADDR_W = $clog2(MEM_DEPTH);

endpackage
